//--- filelist.f
+incdir+test
hw/trig_pkg.sv
hw/axil_subordinate.sv
hw/trig_delay_counter.sv
hw/trig_reg_bank.sv
hw/trig_unit.sv
test/trig_unit_tb.sv

//--- test/trig_tb_tasks.svh
localparam int handshake_limit = 32;

int                         errors;
int                         checks;
logic [31:0]                lcg_state;

logic [n_trigger-1:0]       mmask;
logic [counter_width-1:0]   mdelay [n_trigger];
int                         fire_old [n_trigger];     // Pulse left over from before an arm.
int                         fire_early [n_trigger];   // Re-arm pulse.
int                         fire_new [n_trigger];
int                         load_at [n_trigger];

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

function automatic int rand_below(input int n);
   return int'((lcg_next() >> 8) % n);
endfunction

// Random upper half, small delay in the counter bits.
function automatic logic [31:0] delay_word(input int base, input int spread);
   logic [31:0] r;
   r = lcg_next();
   return {r[31:16], 16'(base + rand_below(spread))};
endfunction

task automatic model_reset();
   mmask = '1;
   for (int i = 0; i < n_trigger; i++) begin
      mdelay[i]     = '0;
      fire_old[i]   = -1;
      fire_early[i] = -1;
      fire_new[i]   = -1;
      load_at[i]    = 0;
   end
endtask

// b is the edge where bvalid rose.
task automatic model_write(input logic [7:0] num, input logic [31:0] data, input int b);
   if (num == trig_pkg::reg_trigger_mask) begin
      mmask = data[n_trigger-1:0];
   end else if (num == trig_pkg::reg_trigger) begin
      for (int i = 0; i < n_trigger; i++) begin
         if (fire_new[i] >= b + 1) begin
            fire_old[i]   = -1;
            fire_early[i] = b + 1;   // Still counting, so it fires at once.
         end else begin
            fire_old[i]   = fire_new[i];
            fire_early[i] = -1;
            load_at[i]    = b + 1;
         end
         fire_new[i] = b + 2 + int'(mdelay[i]);
      end
   end else begin
      for (int i = 0; i < n_trigger; i++) begin
         if (num == trig_pkg::reg_delay_base + i) begin
            mdelay[i] = data[counter_width-1:0];
         end
      end
   end
endtask

// e is the edge where arready was given.
function automatic logic [31:0] model_read(input logic [7:0] num, input int e);
   logic [31:0] v;
   logic        all_armed;
   v = '0;
   all_armed = 1'b1;
   if (num == trig_pkg::reg_trigger_mask) begin
      v[n_trigger-1:0] = mmask;
   end else if (num == trig_pkg::reg_trigger) begin
      for (int i = 0; i < n_trigger; i++) begin
         if (!(load_at[i] <= e && e < fire_new[i])) begin
            all_armed = 1'b0;
         end
      end
      v[0] = all_armed;
   end else begin
      for (int i = 0; i < n_trigger; i++) begin
         if (num == trig_pkg::reg_delay_base + i) begin
            v[counter_width-1:0] = mdelay[i];
         end
      end
   end
   return v;
endfunction

function automatic logic [n_trigger-1:0] expected_triggers(input int c);
   logic [n_trigger-1:0] t;
   for (int i = 0; i < n_trigger; i++) begin
      t[i] = mmask[i] && (c == fire_old[i] || c == fire_early[i] || c == fire_new[i]);
   end
   return t;
endfunction

function automatic int last_fire();
   int m;
   m = 0;
   for (int i = 0; i < n_trigger; i++) begin
      if (fire_new[i] > m) begin
         m = fire_new[i];
      end
   end
   return m;
endfunction

task automatic report_error(input string msg);
   errors++;
   $display("** Error at time %0t: %s", $time, msg);
endtask

task automatic report_hang(input string what);
   errors++;
   $display("Bus handshake never completed: no %s within %0d cycles", what, handshake_limit);
endtask

task automatic check_rdata(input logic [trig_pkg::data_width-1:0] got, expected,
                           input string what);
   checks++;
   if (got !== expected) begin
      report_error($sformatf("%s read 0x%08h, expected 0x%08h", what, got, expected));
   end
endtask

task automatic check_triggers(input logic [n_trigger-1:0] got, expected);
   checks++;
   if (got !== expected) begin
      report_error($sformatf("cycle %0d triggers 0x%0h, expected 0x%0h", cyc, got, expected));
   end
endtask

task automatic bus_write(input logic [trig_pkg::reg_addr_bits-1:0] num,
                         input logic [trig_pkg::data_width-1:0] data, input int hold);
   logic [31:0] r;
   int          n;
   r = lcg_next();
   @(negedge axilite);
   wr_req.awvalid = 1'b1;
   wr_req.awaddr  = {num, r[1:0]};   // Random byte offset.
   wr_req.wvalid  = 1'b1;
   wr_req.wdata   = data;
   wr_req.bready  = (hold == 0);
   n = 0;
   do begin
      @(negedge axilite);
      n++;
   end while (!wr_rsp.awready && n < handshake_limit);
   wr_req.awvalid = 1'b0;
   wr_req.wvalid  = 1'b0;
   if (!wr_rsp.awready) begin
      wr_req.bready = 1'b1;
      report_hang($sformatf("awready for register %0d", num));
      return;
   end
   if (!wr_rsp.wready) begin
      report_error("wready not given together with awready");
   end
   n = 0;
   do begin
      @(negedge axilite);
      n++;
   end while (!wr_rsp.bvalid && n < handshake_limit);
   if (!wr_rsp.bvalid) begin
      wr_req.bready = 1'b1;
      report_hang($sformatf("bvalid for register %0d", num));
      return;
   end
   model_write(num, data, cyc);
   repeat (hold) begin
      @(negedge axilite);
      if (!wr_rsp.bvalid) begin
         report_error("bvalid dropped while bready was low");
      end
   end
   wr_req.bready = 1'b1;
   n = 0;
   do begin
      @(negedge axilite);
      n++;
   end while (wr_rsp.bvalid && n < handshake_limit);
   if (wr_rsp.bvalid) begin
      report_hang("bvalid release");
   end
endtask

task automatic bus_read(input logic [trig_pkg::reg_addr_bits-1:0] num, input int hold,
                        output logic [trig_pkg::data_width-1:0] data, output int e);
   int n;
   data = 'x;
   e    = cyc;
   @(negedge axilite);
   rd_req.arvalid = 1'b1;
   rd_req.araddr  = {num, 2'b00};
   rd_req.rready  = (hold == 0);
   n = 0;
   do begin
      @(negedge axilite);
      n++;
   end while (!rd_rsp.arready && n < handshake_limit);
   rd_req.arvalid = 1'b0;
   e = cyc;
   if (!rd_rsp.arready) begin
      rd_req.rready = 1'b1;
      report_hang($sformatf("arready for register %0d", num));
      return;
   end
   n = 0;
   do begin
      @(negedge axilite);
      n++;
   end while (!rd_rsp.rvalid && n < handshake_limit);
   if (!rd_rsp.rvalid) begin
      rd_req.rready = 1'b1;
      report_hang($sformatf("rvalid for register %0d", num));
      return;
   end
   data = rd_rsp.rdata;
   repeat (hold) begin
      @(negedge axilite);
      if (!rd_rsp.rvalid || rd_rsp.rdata !== data) begin
         report_error("rvalid or rdata changed while rready was low");
      end
   end
   rd_req.rready = 1'b1;
   n = 0;
   do begin
      @(negedge axilite);
      n++;
   end while (rd_rsp.rvalid && n < handshake_limit);
   if (rd_rsp.rvalid) begin
      report_hang("rvalid release");
   end
endtask

task automatic read_check(input logic [trig_pkg::reg_addr_bits-1:0] num, input int hold);
   logic [trig_pkg::data_width-1:0] d;
   int                              e;
   bus_read(num, hold, d, e);
   check_rdata(d, model_read(num, e), $sformatf("register %0d", num));
endtask

//--- test/trig_unit_tb.sv
`timescale 1ns/1ps

module trig_unit_tb;

   localparam int n_trigger     = 8;
   localparam int counter_width = 16;

   logic                      axilite;
   logic                      rstn;
   trig_pkg::axil_wr_req_t    wr_req;
   trig_pkg::axil_wr_rsp_t    wr_rsp;
   trig_pkg::axil_rd_req_t    rd_req;
   trig_pkg::axil_rd_rsp_t    rd_rsp;
   logic [n_trigger-1:0]      triggers;
   int                        cyc;
   logic                      track;
   int                        tests_run;
   int                        tests_failed;

   `include "trig_tb_tasks.svh"

   localparam int n_bus_ops        = 100;   // About 91 transfers in all tests.
   localparam int fire_wait_cycles = 500;
   localparam int watchdog_cycles  =
      n_bus_ops * (3 * handshake_limit + 8) + fire_wait_cycles + 200;

   trig_unit #(
      .n_trigger     (n_trigger),
      .counter_width (counter_width)
   ) dut0 (
      .axilite   (axilite),
      .rstn      (rstn),
      .wr_req    (wr_req),
      .wr_rsp    (wr_rsp),
      .rd_req    (rd_req),
      .rd_rsp    (rd_rsp),
      .triggers  (triggers)
   );

   initial axilite = 1'b0;
   always #5 axilite = ~axilite;

   always @(posedge axilite) cyc <= cyc + 1;

   // Pulse checker, every cycle after reset.
   always begin
      @(negedge axilite);
      #1;
      if (track) begin
         check_triggers(triggers, expected_triggers(cyc));
      end
   end

   initial begin
      #(watchdog_cycles * 10);
      $display("Watchdog expired: the run did not finish within %0d cycles", watchdog_cycles);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic finish_test(input string name, input int start);
      tests_run++;
      if (errors > start) begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - start);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   task automatic wait_fired();
      while (cyc <= last_fire()) begin
         @(negedge axilite);
      end
      repeat (2) @(negedge axilite);
   endtask

   task automatic write_delays(input int base, input int spread);
      for (int i = 0; i < n_trigger; i++) begin
         bus_write(trig_pkg::reg_delay_base + i, delay_word(base, spread), 0);
      end
   endtask

   task automatic reset_values();
      int start;
      start = errors;
      read_check(trig_pkg::reg_trigger_mask, 0);
      read_check(trig_pkg::reg_trigger, 0);
      for (int i = 0; i < n_trigger; i++) begin
         read_check(trig_pkg::reg_delay_base + i, 0);
      end
      finish_test("reset values", start);
   endtask

   task automatic reg_readback();
      int                                 start;
      int                                 k;
      logic [trig_pkg::reg_addr_bits-1:0] num;
      start = errors;
      repeat (16) begin
         k = rand_below(4);
         case (k)
            0: num = trig_pkg::reg_trigger_mask;
            3: num = trig_pkg::reg_delay_base + n_trigger + rand_below(254 - n_trigger);
            default: num = trig_pkg::reg_delay_base + rand_below(n_trigger);
         endcase
         bus_write(num, lcg_next(), 0);
         read_check(num, 0);
      end
      finish_test("register readback", start);
   endtask

   task automatic arm_and_fire();
      int start;
      start = errors;
      bus_write(trig_pkg::reg_trigger_mask, lcg_next(), 0);
      write_delays(0, 64);
      bus_write(trig_pkg::reg_trigger, lcg_next(), 0);
      wait_fired();
      finish_test("arm and fire", start);
   endtask

   task automatic armed_status();
      int start;
      start = errors;
      bus_write(trig_pkg::reg_trigger_mask, '1, 0);
      write_delays(200, 50);   // Long enough to read while counting.
      bus_write(trig_pkg::reg_trigger, 32'd0, 0);
      read_check(trig_pkg::reg_trigger, 0);
      wait_fired();
      read_check(trig_pkg::reg_trigger, 0);
      finish_test("armed status", start);
   endtask

   task automatic rearm_while_counting();
      int start;
      start = errors;
      write_delays(20, 30);
      bus_write(trig_pkg::reg_trigger, 32'd0, 0);
      repeat (rand_below(8)) @(negedge axilite);
      bus_write(trig_pkg::reg_trigger, 32'd0, 0);
      wait_fired();
      finish_test("rearm while counting", start);
   endtask

   task automatic bus_backpressure();
      int                                 start;
      int                                 k;
      logic [trig_pkg::reg_addr_bits-1:0] num;
      logic [trig_pkg::data_width-1:0]    data;
      start = errors;
      repeat (8) begin
         k = rand_below(n_trigger + 1);
         if (k == n_trigger) begin
            num  = trig_pkg::reg_trigger_mask;
            data = lcg_next();
         end else begin
            num  = trig_pkg::reg_delay_base + k;
            data = delay_word(0, 64);
         end
         bus_write(num, data, 1 + rand_below(5));
         read_check(num, 1 + rand_below(5));
      end
      bus_write(trig_pkg::reg_trigger, 32'd0, 1 + rand_below(5));
      wait_fired();
      finish_test("bus backpressure", start);
   endtask

   initial begin
      rstn          = 1'b0;
      wr_req        = '0;
      wr_req.bready = 1'b1;
      rd_req        = '0;
      rd_req.rready = 1'b1;
      cyc           = 0;
      track         = 1'b0;
      errors        = 0;
      checks        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      lcg_state     = 32'hd3f5;
      model_reset();
      repeat (2) @(posedge axilite);
      @(negedge axilite);
      rstn  = 1'b1;
      track = 1'b1;
      reset_values();
      reg_readback();
      arm_and_fire();
      armed_status();
      rearm_while_counting();
      bus_backpressure();
      $display("%0d tests run, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- hw/trig_unit.sv
`timescale 1ns/1ps

module trig_unit #(
   parameter int n_trigger     = 8,
   parameter int counter_width = 16
) (
   input  logic                      axilite,
   input  logic                      rstn,
   input  trig_pkg::axil_wr_req_t    wr_req,
   output trig_pkg::axil_wr_rsp_t    wr_rsp,
   input  trig_pkg::axil_rd_req_t    rd_req,
   output trig_pkg::axil_rd_rsp_t    rd_rsp,
   output logic [n_trigger-1:0]      triggers
);

   trig_pkg::reg_wr_t                        reg_wr;
   logic [trig_pkg::reg_addr_bits-1:0]       rd_num;
   logic [trig_pkg::data_width-1:0]          rd_data;

   axil_subordinate u_sub (
      .axilite   (axilite),
      .rstn      (rstn),
      .wr_req    (wr_req),
      .wr_rsp    (wr_rsp),
      .rd_req    (rd_req),
      .rd_rsp    (rd_rsp),
      .reg_wr    (reg_wr),
      .rd_num    (rd_num),
      .rd_data   (rd_data)
   );

   trig_reg_bank #(
      .n_trigger     (n_trigger),
      .counter_width (counter_width)
   ) u_bank (
      .axilite   (axilite),
      .rstn      (rstn),
      .reg_wr    (reg_wr),
      .rd_num    (rd_num),
      .rd_data   (rd_data),
      .triggers  (triggers)
   );

endmodule

//--- hw/trig_reg_bank.sv
`timescale 1ns/1ps

module trig_reg_bank #(
   parameter int n_trigger     = 8,
   parameter int counter_width = 16
) (
   input  logic                                 axilite,
   input  logic                                 rstn,
   input  trig_pkg::reg_wr_t                    reg_wr,
   input  logic [trig_pkg::reg_addr_bits-1:0]   rd_num,
   output logic [trig_pkg::data_width-1:0]      rd_data,
   output logic [n_trigger-1:0]                 triggers
);

   logic                           arm;
   logic [n_trigger-1:0]           mask;
   logic [n_trigger-1:0]           armed;
   logic [n_trigger-1:0]           trigger_raw;
   logic [counter_width-1:0]       delay_reg [n_trigger];

   // Channel mask.
   always_ff @(posedge axilite) begin
      if (!rstn) begin
         mask <= '1;
      end else if (reg_wr.en && reg_wr.num == trig_pkg::reg_trigger_mask) begin
         mask <= reg_wr.data[n_trigger-1:0];
      end
   end

   // Delays keep only the low counter bits.
   always_ff @(posedge axilite) begin
      if (!rstn) begin
         for (int i = 0; i < n_trigger; i++) begin
            delay_reg[i] <= '0;
         end
      end else if (reg_wr.en) begin
         for (int i = 0; i < n_trigger; i++) begin
            if (reg_wr.num == trig_pkg::reg_delay_base + i) begin
               delay_reg[i] <= reg_wr.data[counter_width-1:0];
            end
         end
      end
   end

   // Arm all channels together.
   always_ff @(posedge axilite) begin
      if (!rstn) begin
         arm <= 1'b0;
      end else begin
         arm <= reg_wr.en && reg_wr.num == trig_pkg::reg_trigger;
      end
   end

   always_comb begin
      rd_data = '0;
      if (rd_num == trig_pkg::reg_trigger_mask) begin
         rd_data[n_trigger-1:0] = mask;
      end else if (rd_num == trig_pkg::reg_trigger) begin
         rd_data[0] = &armed;   // All channels still counting.
      end else begin
         for (int i = 0; i < n_trigger; i++) begin
            if (rd_num == trig_pkg::reg_delay_base + i) begin
               rd_data[counter_width-1:0] = delay_reg[i];
            end
         end
      end
   end

   for (genvar i = 0; i < n_trigger; i++) begin : g_chan
      trig_delay_counter #(
         .counter_width (counter_width)
      ) u_counter (
         .axilite       (axilite),
         .rstn          (rstn),
         .arm           (arm),
         .wait_cycles   (delay_reg[i]),
         .armed         (armed[i]),
         .trigger       (trigger_raw[i])
      );
   end

   // Masked channels keep counting but stay quiet.
   assign triggers = trigger_raw & mask;

endmodule

//--- hw/trig_delay_counter.sv
`timescale 1ns/1ps

module trig_delay_counter #(
   parameter int counter_width = 16
) (
   input  logic                        axilite,
   input  logic                        rstn,
   input  logic                        arm,
   input  logic [counter_width-1:0]    wait_cycles,
   output logic                        armed,
   output logic                        trigger
);

   logic [counter_width-1:0]           counter;

   always_ff @(posedge axilite) begin
      if (!rstn) begin
         armed   <= 1'b0;
         trigger <= 1'b0;
      end else if (armed) begin
         if (arm) begin
            trigger <= 1'b1;   // Early fire, then restart.
            counter <= wait_cycles;
         end else if (counter != '0) begin
            trigger <= 1'b0;
            counter <= counter - 1'b1;
         end else begin
            trigger <= 1'b1;
            armed   <= 1'b0;
         end
      end else begin
         trigger <= 1'b0;
         if (arm) begin
            armed   <= 1'b1;
            counter <= wait_cycles;
         end
      end
   end

endmodule

//--- hw/axil_subordinate.sv
`timescale 1ns/1ps

module axil_subordinate (
   input  logic                                    axilite,
   input  logic                                    rstn,
   input  trig_pkg::axil_wr_req_t                  wr_req,
   output trig_pkg::axil_wr_rsp_t                  wr_rsp,
   input  trig_pkg::axil_rd_req_t                  rd_req,
   output trig_pkg::axil_rd_rsp_t                  rd_rsp,
   output trig_pkg::reg_wr_t                       reg_wr,
   output logic [trig_pkg::reg_addr_bits-1:0]      rd_num,
   input  logic [trig_pkg::data_width-1:0]         rd_data
);

   typedef enum logic [1:0] {
      st_idle,
      st_wresp,
      st_raddr,
      st_rdata
   } state_t;

   state_t                                 state;

   logic                                   awready;
   logic                                   wready;
   logic                                   bvalid;
   logic                                   arready;
   logic                                   rvalid;
   logic [trig_pkg::data_width-1:0]        rdata;

   logic                                   wr_en;
   logic [trig_pkg::reg_addr_bits-1:0]     wr_num;
   logic [trig_pkg::data_width-1:0]        wr_data;

   assign wr_rsp = '{awready: awready, wready: wready, bvalid: bvalid};
   assign rd_rsp = '{arready: arready, rvalid: rvalid, rdata: rdata};
   assign reg_wr = '{en: wr_en, num: wr_num, data: wr_data};

   always_ff @(posedge axilite) begin
      if (!rstn) begin
         state   <= st_idle;
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         arready <= 1'b0;
         rvalid  <= 1'b0;
         wr_en   <= 1'b0;
      end else begin
         awready <= 1'b0;   // Ready and strobe are single-cycle.
         wready  <= 1'b0;
         arready <= 1'b0;
         wr_en   <= 1'b0;
         case (state)
            st_idle: begin
               // Write has priority over read.
               if (wr_req.awvalid && wr_req.wvalid) begin
                  awready <= 1'b1;
                  wready  <= 1'b1;
                  wr_en   <= 1'b1;
                  state   <= st_wresp;
               end else if (rd_req.arvalid) begin
                  arready <= 1'b1;
                  state   <= st_raddr;
               end
            end
            st_wresp: begin
               if (bvalid && wr_req.bready) begin
                  bvalid <= 1'b0;
                  state  <= st_idle;
               end else begin
                  bvalid <= 1'b1;
               end
            end
            st_raddr: begin
               rvalid <= 1'b1;   // Bank data is valid one cycle after latch.
               state  <= st_rdata;
            end
            st_rdata: begin
               if (rd_req.rready) begin
                  rvalid <= 1'b0;
                  state  <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Address and data capture.
   always_ff @(posedge axilite) begin
      if (state == st_idle) begin
         if (wr_req.awvalid && wr_req.wvalid) begin
            wr_num  <= wr_req.awaddr[trig_pkg::reg_addr_bits+1:2];   // Drop byte offset.
            wr_data <= wr_req.wdata;
         end else if (rd_req.arvalid) begin
            rd_num  <= rd_req.araddr[trig_pkg::reg_addr_bits+1:2];
         end
      end
      if (state == st_raddr) begin
         rdata <= rd_data;   // Held stable while rvalid waits.
      end
   end

endmodule

//--- hw/trig_pkg.sv
package trig_pkg;

   localparam int data_width    = 32;
   localparam int reg_addr_bits = 8;   // Register number, byte address >> 2.

   localparam logic [reg_addr_bits-1:0] reg_trigger_mask = 8'd0;
   localparam logic [reg_addr_bits-1:0] reg_trigger      = 8'd1;
   localparam logic [reg_addr_bits-1:0] reg_delay_base   = 8'd2;   // Channel i at 2+i.

   typedef struct packed {
      logic                       awvalid;
      logic [reg_addr_bits+1:0]   awaddr;
      logic                       wvalid;
      logic [data_width-1:0]      wdata;
      logic                       bready;
   } axil_wr_req_t;

   // Response is always OKAY, so bresp is not carried.
   typedef struct packed {
      logic                       awready;
      logic                       wready;
      logic                       bvalid;
   } axil_wr_rsp_t;

   typedef struct packed {
      logic                       arvalid;
      logic [reg_addr_bits+1:0]   araddr;
      logic                       rready;
   } axil_rd_req_t;

   typedef struct packed {
      logic                       arready;
      logic                       rvalid;
      logic [data_width-1:0]      rdata;
   } axil_rd_rsp_t;

   typedef struct packed {
      logic                       en;     // One-cycle strobe.
      logic [reg_addr_bits-1:0]   num;
      logic [data_width-1:0]      data;
   } reg_wr_t;

endpackage
